//--- dot_entry.f
+incdir+rtl
rtl/dot_entry_pkg.sv
rtl/entry_sequencer.sv
rtl/vector_bank.sv
rtl/mac_engine.sv
rtl/hex_display.sv
rtl/dot_entry_top.sv
dv/dot_entry_checker.sv
dv/dot_entry_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = dot_entry_tb
FILELIST  = dot_entry.f
SIM_ARGS  = +verilator+error+limit+1000
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = NO ERRORS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/dot_entry_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "dot_entry_consts.svh"

module dot_entry_tb
	import dot_entry_pkg::*;
();

	logic       clk2 = 1'b0;
	logic       rst;
	logic       next_trigger;
	logic       key_valid;
	nibble_t    key_nibble;
	logic [3:0] phase_code;
	logic [7:0] tracker;
	seg_t       seg0;
	seg_t       seg1;
	seg_t       seg2;
	seg_t       seg3;
	word_t      dot_result;

	int     errors = 0;
	int     tests_run = 0;
	int     tests_failed = 0;
	integer seed = 28;
	word_t  vec_a [`DOT_ELEMS];
	word_t  vec_b [`DOT_ELEMS];

	// Active-low digit patterns 0 to F
	localparam seg_t SEG_TAB [16] = '{
		8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
		8'h80, 8'h98, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E
	};

	always #4 clk2 = ~clk2;    // 8 ns period

	dot_entry_top dut_i (
		.clk2         (clk2),
		.rst          (rst),
		.next_trigger (next_trigger),
		.key_valid    (key_valid),
		.key_nibble   (key_nibble),
		.phase_code   (phase_code),
		.tracker      (tracker),
		.seg0         (seg0),
		.seg1         (seg1),
		.seg2         (seg2),
		.seg3         (seg3),
		.dot_result   (dot_result)
	);

	// ----------------------------------------
	// Compare tasks
	// ----------------------------------------
	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_seg(input string name, input seg_t got, input seg_t exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_code(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic verify_display(input word_t w);
		check_seg("seg0", seg0, SEG_TAB[w[3:0]]);
		check_seg("seg1", seg1, SEG_TAB[w[7:4]]);
		check_seg("seg2", seg2, SEG_TAB[w[11:8]]);
		check_seg("seg3", seg3, SEG_TAB[w[15:12]]);
	endtask

	// ----------------------------------------
	// Drivers
	// ----------------------------------------
	task automatic apply_reset();
		rst          = 1'b1;
		next_trigger = 1'b0;
		key_valid    = 1'b0;
		key_nibble   = '0;
		repeat (4) @(posedge clk2);
		#1 rst = 1'b0;
	endtask

	task automatic press_key(input nibble_t nib);
		key_valid  = 1'b1;
		key_nibble = nib;
		@(posedge clk2);
		#1 key_valid = 1'b0;
	endtask

	task automatic pulse_trigger();
		next_trigger = 1'b1;
		@(posedge clk2);
		#1 next_trigger = 1'b0;
	endtask

	task automatic enter_word(input word_t w);
		for (int i = 0; i < `DOT_NIBS; i++)
			press_key(w[i*`DOT_NIB_W +: `DOT_NIB_W]);    // Low nibble first
	endtask

	task automatic load_vector(input logic sel_b);
		for (int i = 0; i < `DOT_ELEMS; i++)
			enter_word(sel_b ? vec_b[i] : vec_a[i]);
	endtask

	task automatic wait_phase(input logic [3:0] code, output int cycles);
		cycles = 0;
		while (phase_code !== code && cycles < 100) begin
			@(posedge clk2);
			#1;
			cycles++;
		end
		if (phase_code !== code) begin
			$display("Timed out after 100 cycles waiting for phase code %h", code);
			errors++;
		end
	endtask

	function automatic word_t expected_dot();
		logic [31:0] acc;
		acc = '0;
		for (int i = 0; i < `DOT_ELEMS; i++)
			acc = acc + 32'(vec_a[i]) * 32'(vec_b[i]);
		return acc[15:0];    // Modulo 65536
	endfunction

	// Third trigger through to the held result
	task automatic run_mac(input word_t exp);
		int cycles;
		pulse_trigger();
		wait_phase(`DOT_COMM_DONE, cycles);
		if (cycles + 1 != 12) begin
			$display("Result phase came %0d cycles after the trigger, not 12", cycles + 1);
			errors++;
		end
		check_word("dot_result", dot_result, exp);
		verify_display(exp);
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests_run++;
		if (errors > errs_before) begin
			tests_failed++;
			$display("%s: failed with %0d errors", name, errors - errs_before);
		end else begin
			$display("%s: passed", name);
		end
	endtask

	// ----------------------------------------
	// Directed tests
	// ----------------------------------------
	task automatic splash_after_reset();
		int e0;
		e0 = errors;
		apply_reset();
		check_code("phase_code", {4'h0, phase_code}, 8'h01);
		check_code("tracker", tracker, 8'hFF);
		check_word("dot_result", dot_result, 16'h0000);
		verify_display(16'h172E);
		finish_test("splash_after_reset", e0);
	endtask

	task automatic entry_echo();
		int    e0;
		word_t w;
		word_t part;
		e0   = errors;
		w    = 16'hA5C3;
		part = '0;
		apply_reset();
		pulse_trigger();
		check_code("phase_code", {4'h0, phase_code}, 8'h02);
		check_code("tracker", tracker, 8'hFE);
		verify_display(16'h0000);
		for (int i = 0; i < 3; i++) begin
			press_key(w[i*4 +: 4]);
			part[i*4 +: 4] = w[i*4 +: 4];
			verify_display(part);
			check_code("tracker", tracker, 8'hFE);
		end
		press_key(w[15:12]);    // Word complete, element 1 next
		verify_display(w);
		check_code("tracker", tracker, 8'hFD);
		press_key(4'h7);
		verify_display(16'h0007);
		check_code("tracker", tracker, 8'hFD);
		check_code("phase_code", {4'h0, phase_code}, 8'h02);
		finish_test("entry_echo", e0);
	endtask

	task automatic directed_dot();
		int e0;
		e0 = errors;
		for (int i = 0; i < `DOT_ELEMS; i++) begin
			vec_a[i] = word_t'(i + 1);
			vec_b[i] = 16'h0002;
		end
		apply_reset();
		pulse_trigger();
		load_vector(1'b0);
		check_code("phase_code", {4'h0, phase_code}, 8'h02);
		check_code("tracker", tracker, 8'hFF);
		verify_display(16'h0008);
		pulse_trigger();
		check_code("phase_code", {4'h0, phase_code}, 8'h04);
		check_code("tracker", tracker, 8'hFE);
		load_vector(1'b1);
		check_code("tracker", tracker, 8'hFF);
		verify_display(16'h0002);
		run_mac(16'h0048);
		finish_test("directed_dot", e0);
	endtask

	task automatic random_dot();
		int e0;
		e0 = errors;
		for (int i = 0; i < `DOT_ELEMS; i++) begin
			vec_a[i] = word_t'($random(seed));
			vec_b[i] = word_t'($random(seed));
		end
		apply_reset();
		pulse_trigger();
		load_vector(1'b0);
		pulse_trigger();
		load_vector(1'b1);
		run_mac(expected_dot());
		finish_test("random_dot", e0);
	endtask

	task automatic ignored_inputs();
		int e0;
		e0 = errors;
		for (int i = 0; i < `DOT_ELEMS; i++) begin
			vec_a[i] = word_t'(291 * i + 3);
			vec_b[i] = word_t'(4660 - 17 * i);
		end
		apply_reset();
		press_key(4'h9);    // Splash phase takes no keys
		press_key(4'h4);
		verify_display(16'h172E);
		check_code("phase_code", {4'h0, phase_code}, 8'h01);
		pulse_trigger();
		press_key(vec_a[0][3:0]);
		press_key(vec_a[0][7:4]);
		pulse_trigger();    // Mid-word, must be dropped
		check_code("phase_code", {4'h0, phase_code}, 8'h02);
		check_code("tracker", tracker, 8'hFE);
		press_key(vec_a[0][11:8]);
		press_key(vec_a[0][15:12]);
		for (int i = 1; i < `DOT_ELEMS; i++)
			enter_word(vec_a[i]);
		press_key(4'hB);
		verify_display(vec_a[7]);
		check_code("phase_code", {4'h0, phase_code}, 8'h02);
		check_code("tracker", tracker, 8'hFF);
		pulse_trigger();
		load_vector(1'b1);
		press_key(4'h6);
		verify_display(vec_b[7]);
		check_code("phase_code", {4'h0, phase_code}, 8'h04);
		run_mac(expected_dot());
		pulse_trigger();    // Done phase ignores triggers
		press_key(4'h1);
		check_code("phase_code", {4'h0, phase_code}, 8'h08);
		check_word("dot_result", dot_result, expected_dot());
		verify_display(expected_dot());
		finish_test("ignored_inputs", e0);
	endtask

	initial begin
		rst          = 1'b1;
		next_trigger = 1'b0;
		key_valid    = 1'b0;
		key_nibble   = '0;
		splash_after_reset();
		entry_echo();
		directed_dot();
		random_dot();
		ignored_inputs();
		errors += dut_i.chk_i.assert_errs;
		$display("Tests run: %0d, tests failed: %0d, errors: %0d",
			tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/dot_entry_checker.sv
`timescale 1ns/10ps
`default_nettype none

`include "dot_entry_consts.svh"

module dot_entry_checker
	import dot_entry_pkg::*;
(
	input logic       clk2,
	input logic       rst,
	input logic [3:0] phase_code,
	input logic [7:0] tracker,
	input word_t      dot_result
);

	int assert_errs = 0;    // Read by the testbench at the end of the run

	// At most one element marked, active low
	tracker_one_cold: assert property (@(posedge clk2) disable iff (rst)
		$countones(~tracker) <= 1)
		else begin
			assert_errs++;
			$error("tracker marks more than one element: %h", tracker);
		end

	phase_one_hot: assert property (@(posedge clk2) disable iff (rst)
		$onehot0(phase_code))
		else begin
			assert_errs++;
			$error("phase_code is neither zero nor one-hot: %h", phase_code);
		end

	// Result frozen once the pass is over
	result_held: assert property (@(posedge clk2) disable iff (rst)
		phase_code == `DOT_COMM_DONE |=> $stable(dot_result))
		else begin
			assert_errs++;
			$error("dot_result moved in the done phase: %h", dot_result);
		end

endmodule

bind dot_entry_top dot_entry_checker chk_i (
	.clk2       (clk2),
	.rst        (rst),
	.phase_code (phase_code),
	.tracker    (tracker),
	.dot_result (dot_result)
);

`default_nettype wire

//--- rtl/dot_entry_top.sv
`timescale 1ns/10ps
`default_nettype none

module dot_entry_top
	import dot_entry_pkg::*;
(
	input  logic       clk2,
	input  logic       rst,
	input  logic       next_trigger,
	input  logic       key_valid,
	input  nibble_t    key_nibble,
	output logic [3:0] phase_code,
	output logic [7:0] tracker,
	output seg_t       seg0,
	output seg_t       seg1,
	output seg_t       seg2,
	output seg_t       seg3,
	output word_t      dot_result
);

	localparam int NBANKS = 2;    // Bank 0 holds A, bank 1 holds B

	logic [NBANKS-1:0] bank_we;
	elem_idx_t         wr_addr;
	elem_idx_t         rd_addr;
	word_t             wr_data;
	word_t             rd_data [NBANKS];
	logic              mac_start;
	logic              mac_done;
	word_t             disp_word;

	entry_sequencer seq_i (
		.clk2         (clk2),
		.rst          (rst),
		.next_trigger (next_trigger),
		.key_valid    (key_valid),
		.key_nibble   (key_nibble),
		.mac_done     (mac_done),
		.mac_sum      (dot_result),
		.bank_we      (bank_we),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.mac_start    (mac_start),
		.disp_word    (disp_word),
		.phase_code   (phase_code),
		.tracker      (tracker)
	);

	// ----------------------------------------
	// Operand banks
	// ----------------------------------------
	for (genvar g = 0; g < NBANKS; g++) begin : g_bank
		vector_bank bank_i (
			.clk2    (clk2),
			.rst     (rst),
			.we      (bank_we[g]),
			.wr_addr (wr_addr),
			.wr_data (wr_data),
			.rd_addr (rd_addr),
			.rd_data (rd_data[g])
		);
	end

	mac_engine mac_i (
		.clk2      (clk2),
		.rst       (rst),
		.mac_start (mac_start),
		.a_data    (rd_data[0]),
		.b_data    (rd_data[1]),
		.rd_addr   (rd_addr),
		.mac_done  (mac_done),
		.mac_sum   (dot_result)
	);

	hex_display disp_i (
		.disp_word (disp_word),
		.seg0      (seg0),
		.seg1      (seg1),
		.seg2      (seg2),
		.seg3      (seg3)
	);

endmodule

`default_nettype wire

//--- rtl/hex_display.sv
`timescale 1ns/10ps
`default_nettype none

module hex_display
	import dot_entry_pkg::*;
(
	input  word_t disp_word,
	output seg_t  seg0,
	output seg_t  seg1,
	output seg_t  seg2,
	output seg_t  seg3
);

	// Active-low segments, decimal point kept dark
	function automatic seg_t seg_of(nibble_t nib);
		case (nib)
			4'h0: seg_of = 8'hC0;
			4'h1: seg_of = 8'hF9;
			4'h2: seg_of = 8'hA4;
			4'h3: seg_of = 8'hB0;
			4'h4: seg_of = 8'h99;
			4'h5: seg_of = 8'h92;
			4'h6: seg_of = 8'h82;
			4'h7: seg_of = 8'hF8;
			4'h8: seg_of = 8'h80;
			4'h9: seg_of = 8'h98;
			4'hA: seg_of = 8'h88;
			4'hB: seg_of = 8'h83;
			4'hC: seg_of = 8'hC6;
			4'hD: seg_of = 8'hA1;
			4'hE: seg_of = 8'h86;
			4'hF: seg_of = 8'h8E;
			default: seg_of = 8'hC0;
		endcase
	endfunction

	assign seg0 = seg_of(disp_word[3:0]);      // Rightmost digit
	assign seg1 = seg_of(disp_word[7:4]);
	assign seg2 = seg_of(disp_word[11:8]);
	assign seg3 = seg_of(disp_word[15:12]);

endmodule

`default_nettype wire

//--- rtl/mac_engine.sv
`timescale 1ns/10ps
`default_nettype none

`include "dot_entry_consts.svh"

module mac_engine
	import dot_entry_pkg::*;
(
	input  logic      clk2,
	input  logic      rst,
	input  logic      mac_start,
	input  word_t     a_data,
	input  word_t     b_data,
	output elem_idx_t rd_addr,
	output logic      mac_done,
	output word_t     mac_sum
);

	localparam elem_idx_t LAST_ELEM = elem_idx_t'(`DOT_ELEMS - 1);

	logic  reading;
	word_t prod_full;
	word_t prod;
	logic  prod_valid;
	logic  prod_last;

	assign prod_full = a_data * b_data;    // Only the low half reaches the sum

	// ----------------------------------------
	// Read counter
	// ----------------------------------------
	always_ff @(posedge clk2 or posedge rst) begin
		if (rst) begin
			reading <= 1'b0;
			rd_addr <= '0;
		end else if (mac_start) begin
			reading <= 1'b1;
			rd_addr <= '0;
		end else if (reading) begin
			rd_addr <= rd_addr + 1'b1;
			if (rd_addr == LAST_ELEM)
				reading <= 1'b0;
		end
	end

	// Stage 1, product register
	always_ff @(posedge clk2 or posedge rst) begin
		if (rst) begin
			prod_valid <= 1'b0;
			prod_last  <= 1'b0;
		end else begin
			prod_valid <= reading;
			prod_last  <= reading && (rd_addr == LAST_ELEM);
		end
	end

	always_ff @(posedge clk2) begin
		prod <= prod_full;
	end

	// Stage 2, accumulator
	always_ff @(posedge clk2 or posedge rst) begin
		if (rst) begin
			mac_sum  <= '0;
			mac_done <= 1'b0;
		end else begin
			mac_done <= prod_valid && prod_last;
			if (mac_start)
				mac_sum <= '0;
			else if (prod_valid)
				mac_sum <= mac_sum + prod;    // Wraps modulo 2^16
		end
	end

endmodule

`default_nettype wire

//--- rtl/vector_bank.sv
`timescale 1ns/10ps
`default_nettype none

`include "dot_entry_consts.svh"

module vector_bank
	import dot_entry_pkg::*;
(
	input  logic      clk2,
	input  logic      rst,
	input  logic      we,
	input  elem_idx_t wr_addr,
	input  word_t     wr_data,
	input  elem_idx_t rd_addr,
	output word_t     rd_data
);

	word_t mem [`DOT_ELEMS];

	// Write port
	always_ff @(posedge clk2 or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < `DOT_ELEMS; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[wr_addr] <= wr_data;
		end
	end

	assign rd_data = mem[rd_addr];    // Same-cycle read for the MAC pass

endmodule

`default_nettype wire

//--- rtl/entry_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "dot_entry_consts.svh"

module entry_sequencer
	import dot_entry_pkg::*;
(
	input  logic                  clk2,
	input  logic                  rst,
	input  logic                  next_trigger,
	input  logic                  key_valid,
	input  nibble_t               key_nibble,
	input  logic                  mac_done,
	input  word_t                 mac_sum,
	output logic [1:0]            bank_we,
	output elem_idx_t             wr_addr,
	output word_t                 wr_data,
	output logic                  mac_start,
	output word_t                 disp_word,
	output logic [3:0]            phase_code,
	output logic [`DOT_ELEMS-1:0] tracker
);

	typedef logic [$clog2(`DOT_NIBS)-1:0] nib_cnt_t;

	localparam nib_cnt_t  LAST_NIB  = nib_cnt_t'(`DOT_NIBS - 1);
	localparam elem_idx_t LAST_ELEM = elem_idx_t'(`DOT_ELEMS - 1);

	phase_e    phase;
	phase_e    phase_nxt;
	nib_cnt_t  nib_cnt;
	nib_cnt_t  nib_nxt;
	elem_idx_t elem_cnt;
	elem_idx_t elem_nxt;
	word_t     word_buf;
	word_t     buf_nxt;
	word_t     disp_nxt;
	word_t     asm_word;
	logic      load_phase;
	logic      word_done;

	function automatic logic [`DOT_ELEMS-1:0] track_of(phase_e ph, elem_idx_t idx);
		if (ph == PH_LOAD_A || ph == PH_LOAD_B)
			return ~(`DOT_ELEMS'(1) << idx);
		return `DOT_TRACK_IDLE;
	endfunction

	// ----------------------------------------
	// Word assembly and bank write
	// ----------------------------------------
	assign load_phase = (phase == PH_LOAD_A) || (phase == PH_LOAD_B);
	assign word_done  = load_phase && key_valid && (nib_cnt == LAST_NIB);

	always_comb begin
		asm_word = word_buf;
		asm_word[nib_cnt*`DOT_NIB_W +: `DOT_NIB_W] = key_nibble;
	end

	assign bank_we[0] = word_done && (phase == PH_LOAD_A);
	assign bank_we[1] = word_done && (phase == PH_LOAD_B);
	assign wr_addr    = elem_cnt;
	assign wr_data    = asm_word;

	// ----------------------------------------
	// Phase FSM
	// ----------------------------------------
	always_comb begin
		phase_nxt = phase;
		nib_nxt   = nib_cnt;
		elem_nxt  = elem_cnt;
		buf_nxt   = word_buf;
		disp_nxt  = disp_word;
		case (phase)
			PH_START, PH_WAIT_B: begin
				if (next_trigger) begin
					phase_nxt = (phase == PH_START) ? PH_LOAD_A : PH_LOAD_B;
					nib_nxt   = '0;
					elem_nxt  = '0;
					buf_nxt   = '0;
					disp_nxt  = '0;      // Fresh element
				end
			end
			PH_LOAD_A, PH_LOAD_B: begin
				if (key_valid) begin
					disp_nxt = asm_word;
					if (word_done) begin
						nib_nxt  = '0;
						buf_nxt  = '0;
						elem_nxt = elem_cnt + 1'b1;
						if (elem_cnt == LAST_ELEM)
							phase_nxt = (phase == PH_LOAD_A) ? PH_WAIT_B : PH_WAIT_MAC;
					end else begin
						nib_nxt = nib_cnt + 1'b1;
						buf_nxt = asm_word;
					end
				end
			end
			PH_WAIT_MAC: if (next_trigger) phase_nxt = PH_MAC;
			PH_MAC: begin
				if (mac_done) begin
					phase_nxt = PH_DONE;
					disp_nxt  = mac_sum;
				end
			end
			PH_DONE: phase_nxt = PH_DONE;    // Held until reset
			default: phase_nxt = PH_START;
		endcase
	end

	always_ff @(posedge clk2 or posedge rst) begin
		if (rst) begin
			phase     <= PH_START;
			nib_cnt   <= '0;
			elem_cnt  <= '0;
			word_buf  <= '0;
			disp_word <= `DOT_SPLASH;
			tracker   <= `DOT_TRACK_IDLE;
			mac_start <= 1'b0;
		end else begin
			phase     <= phase_nxt;
			nib_cnt   <= nib_nxt;
			elem_cnt  <= elem_nxt;
			word_buf  <= buf_nxt;
			disp_word <= disp_nxt;
			tracker   <= track_of(phase_nxt, elem_nxt);
			mac_start <= (phase == PH_WAIT_MAC) && next_trigger;   // One pulse on entry to PH_MAC
		end
	end

	always_comb begin
		case (phase)
			PH_START:               phase_code = `DOT_COMM_START;
			PH_LOAD_A, PH_WAIT_B:   phase_code = `DOT_COMM_LOAD_A;
			PH_LOAD_B, PH_WAIT_MAC: phase_code = `DOT_COMM_LOAD_B;
			PH_DONE:                phase_code = `DOT_COMM_DONE;
			default:                phase_code = 4'h0;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/dot_entry_pkg.sv
`default_nettype none

`include "dot_entry_consts.svh"

package dot_entry_pkg;

	// Sequencer phases in visiting order
	typedef enum logic [2:0] {
		PH_START,
		PH_LOAD_A,
		PH_WAIT_B,
		PH_LOAD_B,
		PH_WAIT_MAC,
		PH_MAC,
		PH_DONE
	} phase_e;

	typedef logic [`DOT_WORD_W-1:0]        word_t;
	typedef logic [`DOT_NIB_W-1:0]         nibble_t;
	typedef logic [$clog2(`DOT_ELEMS)-1:0] elem_idx_t;
	typedef logic [`DOT_SEG_W-1:0]         seg_t;      // Active low, bit 7 is the point

endpackage

`default_nettype wire

//--- rtl/dot_entry_consts.svh
`ifndef DOT_ENTRY_CONSTS_SVH
`define DOT_ENTRY_CONSTS_SVH

// ----------------------------------------
// Vector and word geometry
// ----------------------------------------
`define DOT_ELEMS       8
`define DOT_WORD_W      16
`define DOT_NIB_W       4
`define DOT_NIBS        4
`define DOT_SEG_W       8

// ----------------------------------------
// Front panel values
// ----------------------------------------
// Tracker with no element under entry
`define DOT_TRACK_IDLE  8'hFF
// Word shown before the first trigger
`define DOT_SPLASH      16'h172E

// Phase codes seen by the host
`define DOT_COMM_START  4'h1
`define DOT_COMM_LOAD_A 4'h2
`define DOT_COMM_LOAD_B 4'h4
`define DOT_COMM_DONE   4'h8

`endif
